// ==== Bender.yml ====
package:
  name: exe_stage

export_include_dirs:
  - source

sources:
  - files:
      - source/mem_pkg.sv
      - source/exe_pkg.sv
      - source/exe_stage_reg.sv
      - source/exe_compute.sv
      - source/exe_mem_req.sv
      - source/exe_top.sv
  - target: test
    files:
      - verif/exe_tb.sv

// ==== exe_stage.f ====
+incdir+source
source/mem_pkg.sv
source/exe_pkg.sv
source/exe_stage_reg.sv
source/exe_compute.sv
source/exe_mem_req.sv
source/exe_top.sv
verif/exe_tb.sv

// ==== source/exe_compute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exe_defines.svh"

module exe_compute import exe_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              flush,
    input  wire id_payload_t cur,
    input  wire              start,
    input  wire              exec_ok,

    output xlen_t            result,
    output logic             compute_ready,
    output logic             mul_pending
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} mul_state_e;

    mul_state_e state, state_nxt;

    xlen_t alu_res;
    xlen_t mag_a;
    xlen_t mag_b;
    logic  is_mul;
    logic  signed_op;
    logic  mul_go;
    logic  mul_done;
    logic  last_step;
    logic  neg;

    logic [2*`EXE_XLEN-1:0]              mcand;
    logic [2*`EXE_XLEN-1:0]              acc;
    logic [2*`EXE_XLEN-1:0]              acc_sum;
    xlen_t                               mplier;
    logic [$clog2(`EXE_MUL_STEPS)-1:0]   steps;
    logic [`EXE_CNT_W-1:0]               stable_cnt;

    always_comb begin
        case (cur.alu_op)
            SUB:     alu_res = cur.src1 - cur.src2;
            AND:     alu_res = cur.src1 & cur.src2;
            OR:      alu_res = cur.src1 | cur.src2;
            XOR:     alu_res = cur.src1 ^ cur.src2;
            SLTU:    alu_res = {{(`EXE_XLEN-1){1'b0}}, cur.src1 < cur.src2};
            default: alu_res = cur.src1 + cur.src2;  // Also the memory address
        endcase
    end

    assign is_mul    = (cur.alu_op == MUL_W) | (cur.alu_op == MULH_W) | (cur.alu_op == MULH_WU);
    assign signed_op = (cur.alu_op == MUL_W) | (cur.alu_op == MULH_W);

    // Unsigned core, sign fixed up on the last step
    assign mag_a = (signed_op & cur.src1[`EXE_XLEN-1]) ? -cur.src1 : cur.src1;
    assign mag_b = (signed_op & cur.src2[`EXE_XLEN-1]) ? -cur.src2 : cur.src2;

    assign mul_go      = start & is_mul & exec_ok;
    assign mul_pending = mul_go | (state == RUN);
    assign mul_done    = (state == DONE) & ~start;
    assign last_step   = steps == ($clog2(`EXE_MUL_STEPS))'(`EXE_MUL_STEPS - 1);
    assign acc_sum     = acc + (mplier[0] ? mcand : '0);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (mul_go) state_nxt = RUN;
            RUN:  if (last_step) state_nxt = DONE;
            DONE: begin
                if (mul_go) begin
                    state_nxt = RUN;
                end else if (start) begin
                    state_nxt = IDLE;  // Next instruction is not a multiply
                end
            end
            default: state_nxt = IDLE;
        endcase
        if (flush) state_nxt = IDLE;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_go) begin
            mcand  <= {{`EXE_XLEN{1'b0}}, mag_a};
            mplier <= mag_b;
            acc    <= '0;
            steps  <= '0;
            neg    <= signed_op & (cur.src1[`EXE_XLEN-1] ^ cur.src2[`EXE_XLEN-1]);
        end else if (state == RUN) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            steps  <= steps + 1'b1;
            acc    <= (last_step & neg) ? -acc_sum : acc_sum;
        end
    end

    // Free-running timer for RDCNTV*
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    always_comb begin
        case (cur.alu_op)
            MUL_W:           result = mul_done ? acc[`EXE_XLEN-1:0] : '0;
            MULH_W, MULH_WU: result = mul_done ? acc[2*`EXE_XLEN-1:`EXE_XLEN] : '0;
            RDCNTVL:         result = stable_cnt[`EXE_XLEN-1:0];
            RDCNTVH:         result = stable_cnt[`EXE_CNT_W-1:`EXE_XLEN];
            default:         result = alu_res;
        endcase
    end

    // Suppressed multiply falls straight through
    assign compute_ready = ~is_mul | ~exec_ok | mul_done;

    a_idle_needs_start: assert property (
        @(posedge clk) disable iff (!resetn) (state == IDLE && !start) |=> state == IDLE
    );

endmodule

`default_nettype wire

// ==== source/exe_defines.svh ====
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

// Datapath widths, fixed by the ISA
`define EXE_XLEN      32
`define EXE_REG_AW    5

// Stable counter, read as two 32-bit halves
`define EXE_CNT_W     64

// Shift-add multiplier, one partial product per cycle
`define EXE_MUL_STEPS 32

// Exception codes
`define ECODE_W       6
`define ECODE_ALE     6'h09  // Address not aligned

`endif

// ==== source/exe_mem_req.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_mem_req import exe_pkg::*, mem_pkg::*; (
    input  wire              exe_valid,
    input  wire id_payload_t cur,
    input  wire xlen_t       addr,
    input  wire              exec_ok,
    input  wire              mem_allowin,
    input  wire              data_sram_addr_ok,

    output sram_req_t        data_sram,
    output logic             ale,
    output logic             mem_ready
);

    logic is_load;
    logic is_store;
    logic is_byte;
    logic is_half;
    logic is_word;
    logic mem_access;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_byte  = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (cur.mem_op)
            LD_B, LD_BU: begin
                is_load = 1'b1;
                is_byte = 1'b1;
            end
            LD_H, LD_HU: begin
                is_load = 1'b1;
                is_half = 1'b1;
            end
            LD_W: begin
                is_load = 1'b1;
                is_word = 1'b1;
            end
            ST_B: begin
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            ST_H: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            ST_W: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: ;  // NONE
        endcase
    end

    assign mem_access = is_load | is_store;

    // Bytes never misalign
    assign ale = exe_valid & ((is_half & addr[0]) | (is_word & (|addr[1:0])));

    always_comb begin
        data_sram.req   = mem_access & exec_ok & mem_allowin;  // Held off by back-pressure
        data_sram.wr    = is_store;
        data_sram.size  = is_word ? 2'd2 : is_half ? 2'd1 : 2'd0;
        data_sram.addr  = addr;                                // No translation
        data_sram.wstrb = '0;
        data_sram.wdata = cur.rkd_value;
        case (cur.mem_op)
            ST_B: begin
                data_sram.wstrb = 4'b0001 << addr[1:0];
                data_sram.wdata = {4{cur.rkd_value[7:0]}};
            end
            ST_H: begin
                data_sram.wstrb = addr[1] ? 4'b1100 : 4'b0011;
                data_sram.wdata = {2{cur.rkd_value[15:0]}};
            end
            ST_W: data_sram.wstrb = 4'b1111;
            default: ;
        endcase
    end

    // Done once the address phase is taken, or nothing to send
    assign mem_ready = ~(mem_access & exec_ok) | (data_sram.req & data_sram_addr_ok);

    // Misaligned accesses never reach the SRAM
    always_comb begin
        a_no_req_on_ale: assert #0 (!(data_sram.req && ale));
    end

endmodule

`default_nettype wire

// ==== source/exe_pkg.sv ====
`default_nettype none

`include "exe_defines.svh"

package exe_pkg;

    import mem_pkg::*;

    typedef logic [`EXE_XLEN-1:0]   xlen_t;
    typedef logic [`EXE_REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ADD     = 4'd0,
        SUB     = 4'd1,
        AND     = 4'd2,
        OR      = 4'd3,
        XOR     = 4'd4,
        SLTU    = 4'd5,
        MUL_W   = 4'd6,   // Low word, signed
        MULH_W  = 4'd7,   // High word, signed
        MULH_WU = 4'd8,   // High word, unsigned
        RDCNTVL = 4'd9,
        RDCNTVH = 4'd10
    } alu_op_e;

    // From decode
    typedef struct packed {
        alu_op_e   alu_op;
        xlen_t     src1;
        xlen_t     src2;
        mem_op_e   mem_op;
        xlen_t     rkd_value;  // Store data
        logic      rf_we;
        reg_addr_t rf_waddr;
        xlen_t     pc;
        logic      ex_valid;   // Exception raised upstream
        ecode_t    ecode;
    } id_payload_t;

    // To memory stage
    typedef struct packed {
        logic      mem_req;    // Request went out to the data SRAM
        mem_op_e   mem_op;
        logic      rf_we;
        reg_addr_t rf_waddr;
        xlen_t     result;
        xlen_t     pc;
        logic      ex_valid;
        ecode_t    ecode;
        xlen_t     badv;
    } exe_payload_t;

    // Bypass back to decode
    typedef struct packed {
        logic      res_from_mem;
        logic      rf_we;
        reg_addr_t rf_waddr;
        xlen_t     result;
    } exe_fwd_t;

endpackage

`default_nettype wire

// ==== source/exe_stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_stage_reg import exe_pkg::*; (
    input  wire              clk,
    input  wire              resetn,
    input  wire              flush,

    input  wire              id_valid,
    input  wire id_payload_t id_payload,
    input  wire              hold,      // Multiply in flight
    input  wire              allowin,

    output logic             exe_valid,
    output id_payload_t      cur,
    output logic             start
);

    logic xfer;

    // Decode hands over an instruction
    assign xfer = id_valid & allowin & ~hold;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else if (flush) begin
            exe_valid <= 1'b0;
        end else if (allowin & ~hold) begin
            exe_valid <= id_valid;
        end
    end

    // One-cycle marker for a freshly loaded instruction
    always_ff @(posedge clk) begin
        if (!resetn) begin
            start <= 1'b0;
        end else begin
            start <= xfer & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            cur <= id_payload;
        end
    end

    a_start_has_valid: assert property (
        @(posedge clk) disable iff (!resetn) start |-> exe_valid
    );

endmodule

`default_nettype wire

// ==== source/exe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exe_defines.svh"

module exe_top import exe_pkg::*, mem_pkg::*; (
    input  wire               clk,
    input  wire               resetn,
    input  wire               flush,

    input  wire               id_valid,
    input  wire id_payload_t  id_payload,
    output logic              exe_allowin,

    input  wire               mem_allowin,
    output logic              exe_to_mem_valid,
    output exe_payload_t      exe_to_mem,

    output sram_req_t         data_sram,
    input  wire               data_sram_addr_ok,

    output exe_fwd_t          exe_fwd,

    input  wire               mem_ex,
    input  wire               wb_ex
);

    id_payload_t cur;
    xlen_t       result;
    logic        exe_valid;
    logic        start;
    logic        exec_ok;
    logic        compute_ready;
    logic        mul_pending;
    logic        mem_ready;
    logic        ale;
    logic        ready_go;
    logic        is_load;

    exe_stage_reg u_stage_reg (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (flush),
        .id_valid   (id_valid),
        .id_payload (id_payload),
        .hold       (mul_pending),
        .allowin    (exe_allowin),
        .exe_valid  (exe_valid),
        .cur        (cur),
        .start      (start)
    );

    exe_compute u_compute (
        .clk           (clk),
        .resetn        (resetn),
        .flush         (flush),
        .cur           (cur),
        .start         (start),
        .exec_ok       (exec_ok),
        .result        (result),
        .compute_ready (compute_ready),
        .mul_pending   (mul_pending)
    );

    exe_mem_req u_mem_req (
        .exe_valid         (exe_valid),
        .cur               (cur),
        .addr              (result),
        .exec_ok           (exec_ok),
        .mem_allowin       (mem_allowin),
        .data_sram_addr_ok (data_sram_addr_ok),
        .data_sram         (data_sram),
        .ale               (ale),
        .mem_ready         (mem_ready)
    );

    // Later stages or this one already faulted
    assign exec_ok = exe_valid & ~(mem_ex | wb_ex | cur.ex_valid | ale);

    assign ready_go         = compute_ready & mem_ready;
    assign exe_allowin      = ~exe_valid | (ready_go & mem_allowin);
    assign exe_to_mem_valid = exe_valid & ready_go;

    assign is_load = (cur.mem_op == LD_B) | (cur.mem_op == LD_H) | (cur.mem_op == LD_W)
                   | (cur.mem_op == LD_BU) | (cur.mem_op == LD_HU);

    always_comb begin
        exe_to_mem.mem_req  = data_sram.req;
        exe_to_mem.mem_op   = cur.mem_op;
        exe_to_mem.rf_we    = cur.rf_we;
        exe_to_mem.rf_waddr = cur.rf_waddr;
        exe_to_mem.result   = result;
        exe_to_mem.pc       = cur.pc;
        exe_to_mem.ex_valid = cur.ex_valid | ale;
        // Upstream exception wins over our own ALE
        exe_to_mem.ecode    = cur.ex_valid ? cur.ecode : ale ? `ECODE_ALE : cur.ecode;
        exe_to_mem.badv     = cur.ex_valid ? cur.pc : result;
    end

    always_comb begin
        exe_fwd.res_from_mem = exe_valid & is_load;  // Value not ready yet
        exe_fwd.rf_we        = exe_valid & cur.rf_we;
        exe_fwd.rf_waddr     = cur.rf_waddr;
        exe_fwd.result       = result;
    end

endmodule

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "exe_defines.svh"

package mem_pkg;

    typedef enum logic [3:0] {
        NONE  = 4'd0,  // No memory access
        LD_B  = 4'd1,
        LD_H  = 4'd2,
        LD_W  = 4'd3,
        LD_BU = 4'd4,
        LD_HU = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8
    } mem_op_e;

    typedef logic [1:0]                sram_size_t;  // 0 byte, 1 half, 2 word
    typedef logic [3:0]                sram_strb_t;
    typedef logic [`EXE_XLEN-1:0]      sram_addr_t;
    typedef logic [`EXE_XLEN-1:0]      sram_data_t;
    typedef logic [`ECODE_W-1:0]       ecode_t;

    typedef struct packed {
        logic       req;
        logic       wr;
        sram_size_t size;
        sram_addr_t addr;
        sram_strb_t wstrb;
        sram_data_t wdata;
    } sram_req_t;

endpackage

`default_nettype wire

// ==== verif/exe_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "exe_defines.svh"

module exe_tb import exe_pkg::*, mem_pkg::*;;

    localparam int TIMEOUT = 200;

    logic         clk;
    logic         resetn;
    logic         flush;
    logic         id_valid;
    id_payload_t  id_payload;
    logic         exe_allowin;
    logic         mem_allowin;
    logic         exe_to_mem_valid;
    exe_payload_t exe_to_mem;
    sram_req_t    data_sram;
    logic         data_sram_addr_ok;
    exe_fwd_t     exe_fwd;
    logic         mem_ex;
    logic         wb_ex;

    logic [31:0]  lfsr_data;  // Operand stream
    logic [31:0]  lfsr_sram;  // addr_ok stream
    int           error_count;

    exe_top i_dut (
        .clk               (clk),
        .resetn            (resetn),
        .flush             (flush),
        .id_valid          (id_valid),
        .id_payload        (id_payload),
        .exe_allowin       (exe_allowin),
        .mem_allowin       (mem_allowin),
        .exe_to_mem_valid  (exe_to_mem_valid),
        .exe_to_mem        (exe_to_mem),
        .data_sram         (data_sram),
        .data_sram_addr_ok (data_sram_addr_ok),
        .exe_fwd           (exe_fwd),
        .mem_ex            (mem_ex),
        .wb_ex             (wb_ex)
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic xlen_t rand_word();
        xlen_t w;
        w = '0;
        for (int k = 0; k < 32; k++) begin
            lfsr_data = lfsr_next(lfsr_data);
            w = {w[30:0], lfsr_data[0]};
        end
        return w;
    endfunction

    // SRAM address phase, accepted on a random bit per cycle
    always @(posedge clk) begin
        #1;
        lfsr_sram = lfsr_next(lfsr_sram);
        data_sram_addr_ok = lfsr_sram[0];
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            error_count++;
            stop_with_error($sformatf("FAILED %s: got 0x%h, expected 0x%h",
                                      name, actual, expected));
        end
    endtask

    function automatic id_payload_t make_instr(input alu_op_e op, input xlen_t a, input xlen_t b,
                                               input mem_op_e m, input xlen_t st);
        id_payload_t p;
        xlen_t       r;
        p = '0;
        p.alu_op = op;
        p.src1 = a;
        p.src2 = b;
        p.mem_op = m;
        p.rkd_value = st;
        r = rand_word();
        p.rf_we = r[5];
        p.rf_waddr = r[4:0];
        p.pc = rand_word() & 32'hffff_fffc;
        return p;
    endfunction

    // ISA results of the single-cycle ops
    function automatic xlen_t alu_expect(input alu_op_e op, input xlen_t a, input xlen_t b);
        logic [32:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        case (op)
            ADD:     return a + b;
            SUB:     return diff[31:0];
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLTU:    return {31'b0, diff[32]};  // Borrow out when a is below b
            default: return 'x;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue(input id_payload_t p);
        int n;
        n = 0;
        next_cycle();
        id_valid = 1'b1;
        id_payload = p;
        #1;
        while (!exe_allowin && n < TIMEOUT) begin
            n++;
            next_cycle();
            #1;
        end
        if (!exe_allowin) begin
            stop_with_error("Timeout: decode could not hand over an instruction");
        end else begin
            next_cycle();  // Taken on this edge
            id_valid = 1'b0;
        end
    endtask

    // Counts the cycles sampled before exe_to_mem_valid
    task automatic wait_out(output int cycles, input logic stall_check);
        cycles = 0;
        #1;
        while (!exe_to_mem_valid && cycles < TIMEOUT) begin
            if (stall_check) check_value("exe_allowin", exe_allowin, 1'b0);
            cycles++;
            next_cycle();
            #1;
        end
        if (!exe_to_mem_valid) stop_with_error("Timeout: no result reached the memory stage");
    endtask

    task automatic test_alu();
        alu_op_e     ops [6] = '{ADD, SUB, AND, OR, XOR, SLTU};
        id_payload_t p;
        xlen_t       a;
        xlen_t       b;
        int          cyc;
        for (int i = 0; i < 24; i++) begin
            a = rand_word();
            b = rand_word();
            p = make_instr(ops[i % 6], a, b, NONE, '0);
            issue(p);
            wait_out(cyc, 1'b0);
            check_value("exe_to_mem.result", exe_to_mem.result, alu_expect(p.alu_op, a, b));
            check_value("exe_fwd.result", exe_fwd.result, alu_expect(p.alu_op, a, b));
            check_value("exe_to_mem.rf_waddr", exe_to_mem.rf_waddr, p.rf_waddr);
            check_value("exe_to_mem.rf_we", exe_to_mem.rf_we, p.rf_we);
            check_value("exe_fwd.rf_we", exe_fwd.rf_we, p.rf_we);
            check_value("exe_fwd.rf_waddr", exe_fwd.rf_waddr, p.rf_waddr);
            check_value("exe_to_mem.pc", exe_to_mem.pc, p.pc);
            check_value("exe_to_mem.ex_valid", exe_to_mem.ex_valid, 1'b0);
            check_value("alu latency", cyc, 0);
        end
    endtask

    task automatic test_mul();
        xlen_t       ma [5] = '{32'hffff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h1234_5678, 32'd3};
        xlen_t       mb [5] = '{32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'hfedc_ba98,
                                32'hffff_fffb};
        alu_op_e     ops [3] = '{MUL_W, MULH_W, MULH_WU};
        id_payload_t p;
        logic [63:0] prod;
        int          cyc;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 3; j++) begin
                if (j == 2) begin
                    prod = {32'b0, ma[i]} * {32'b0, mb[i]};
                end else begin
                    prod = $signed({{32{ma[i][31]}}, ma[i]}) * $signed({{32{mb[i][31]}}, mb[i]});
                end
                p = make_instr(ops[j], ma[i], mb[i], NONE, '0);
                issue(p);
                wait_out(cyc, 1'b1);
                check_value("exe_to_mem.result", exe_to_mem.result,
                            (j == 0) ? prod[31:0] : prod[63:32]);
                check_value("multiply latency", cyc, `EXE_MUL_STEPS + 1);
            end
        end
    endtask

    task automatic test_mem_access();
        mem_op_e     sops [7] = '{ST_B, ST_B, ST_B, ST_B, ST_H, ST_H, ST_W};
        int          offs [7] = '{0, 1, 2, 3, 0, 2, 0};
        id_payload_t p;
        xlen_t       base;
        xlen_t       data;
        xlen_t       addr;
        xlen_t       mask;
        sram_strb_t  strb;
        int          cyc;
        for (int i = 0; i < 7; i++) begin
            base = rand_word() & 32'hffff_fffc;
            data = rand_word();
            p = make_instr(ADD, base, (rand_word() & 32'h0000_fff0) | offs[i], sops[i], data);
            addr = p.src1 + p.src2;
            strb = (sops[i] == ST_W) ? 4'b1111 :
                   (sops[i] == ST_H) ? 4'b0011 << offs[i] : 4'b0001 << offs[i];
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            issue(p);
            wait_out(cyc, 1'b0);
            check_value("data_sram.req", data_sram.req, 1'b1);
            check_value("data_sram.wr", data_sram.wr, 1'b1);
            check_value("data_sram.size", data_sram.size,
                        (sops[i] == ST_W) ? 2'd2 : (sops[i] == ST_H) ? 2'd1 : 2'd0);
            check_value("data_sram.addr", data_sram.addr, addr);
            check_value("data_sram.wstrb", data_sram.wstrb, strb);
            check_value("data_sram.wdata", data_sram.wdata & mask, (data << (8 * offs[i])) & mask);
            check_value("exe_to_mem.mem_req", exe_to_mem.mem_req, 1'b1);
            check_value("exe_to_mem.mem_op", exe_to_mem.mem_op, sops[i]);
            check_value("exe_fwd.res_from_mem", exe_fwd.res_from_mem, 1'b0);
        end
        // Aligned word load
        p = make_instr(ADD, rand_word() & 32'hffff_fffc, 32'd8, LD_W, '0);
        issue(p);
        wait_out(cyc, 1'b0);
        check_value("data_sram.wr", data_sram.wr, 1'b0);
        check_value("data_sram.wstrb", data_sram.wstrb, 4'b0000);
        check_value("exe_to_mem.mem_op", exe_to_mem.mem_op, LD_W);
        check_value("exe_fwd.res_from_mem", exe_fwd.res_from_mem, 1'b1);
    endtask

    task automatic test_align();
        mem_op_e     aops [4] = '{ST_H, ST_W, LD_W, LD_HU};
        int          aoffs [4] = '{1, 2, 3, 1};
        id_payload_t p;
        xlen_t       addr;
        int          cyc;
        for (int i = 0; i < 4; i++) begin
            p = make_instr(ADD, rand_word() & 32'hffff_fffc, aoffs[i], aops[i], rand_word());
            addr = p.src1 + p.src2;
            issue(p);
            wait_out(cyc, 1'b0);
            check_value("data_sram.req", data_sram.req, 1'b0);
            check_value("exe_to_mem.ex_valid", exe_to_mem.ex_valid, 1'b1);
            check_value("exe_to_mem.ecode", exe_to_mem.ecode, `ECODE_ALE);
            check_value("exe_to_mem.badv", exe_to_mem.badv, addr);
        end
        // Upstream exception keeps its own code even when misaligned
        p = make_instr(ADD, rand_word() & 32'hffff_fffc, 32'd2, ST_W, rand_word());
        p.ex_valid = 1'b1;
        p.ecode = 6'h0b;
        issue(p);
        wait_out(cyc, 1'b0);
        check_value("data_sram.req", data_sram.req, 1'b0);
        check_value("exe_to_mem.ex_valid", exe_to_mem.ex_valid, 1'b1);
        check_value("exe_to_mem.ecode", exe_to_mem.ecode, 6'h0b);
        check_value("exe_to_mem.badv", exe_to_mem.badv, p.pc);
    endtask

    task automatic test_stall();
        id_payload_t p;
        xlen_t       held;
        xlen_t       addr;
        int          cyc;
        p = make_instr(XOR, rand_word(), rand_word(), NONE, '0);
        issue(p);
        mem_allowin = 1'b0;
        wait_out(cyc, 1'b0);
        held = exe_to_mem.result;
        repeat (5) begin
            next_cycle();
            #1;
            check_value("exe_to_mem_valid", exe_to_mem_valid, 1'b1);
            check_value("exe_to_mem.result", exe_to_mem.result, held);
            check_value("exe_allowin", exe_allowin, 1'b0);
        end
        next_cycle();
        mem_allowin = 1'b1;
        // Store held off by back-pressure
        p = make_instr(ADD, rand_word() & 32'hffff_fffc, 32'd4, ST_W, rand_word());
        addr = p.src1 + p.src2;
        issue(p);
        mem_allowin = 1'b0;
        repeat (5) begin
            #1;
            check_value("data_sram.req", data_sram.req, 1'b0);
            check_value("exe_to_mem_valid", exe_to_mem_valid, 1'b0);
            next_cycle();
        end
        mem_allowin = 1'b1;
        wait_out(cyc, 1'b0);
        check_value("data_sram.addr", data_sram.addr, addr);
        // Load killed by a later-stage exception
        p = make_instr(ADD, rand_word() & 32'hffff_fffc, 32'd0, LD_W, '0);
        issue(p);
        mem_ex = 1'b1;
        wait_out(cyc, 1'b0);
        check_value("data_sram.req", data_sram.req, 1'b0);
        check_value("exe_to_mem.mem_req", exe_to_mem.mem_req, 1'b0);
        next_cycle();
        mem_ex = 1'b0;
        // Flush in the middle of a multiply
        p = make_instr(MUL_W, rand_word(), rand_word(), NONE, '0);
        issue(p);
        repeat (6) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        repeat (`EXE_MUL_STEPS + 4) begin
            #1;
            check_value("exe_to_mem_valid", exe_to_mem_valid, 1'b0);
            check_value("exe_allowin", exe_allowin, 1'b1);
            next_cycle();
        end
        p = make_instr(SUB, rand_word(), rand_word(), NONE, '0);
        issue(p);
        wait_out(cyc, 1'b0);
        check_value("exe_to_mem.result", exe_to_mem.result, alu_expect(SUB, p.src1, p.src2));
    endtask

    task automatic test_counter();
        id_payload_t p;
        xlen_t       first;
        int          cyc;
        p = make_instr(RDCNTVL, '0, '0, NONE, '0);
        issue(p);
        wait_out(cyc, 1'b0);
        first = exe_to_mem.result;
        repeat (7) next_cycle();
        issue(p);
        wait_out(cyc, 1'b0);
        check_value("rdcntvl increasing", exe_to_mem.result > first, 1'b1);
        p.alu_op = RDCNTVH;
        issue(p);
        wait_out(cyc, 1'b0);
        check_value("exe_to_mem.result", exe_to_mem.result, '0);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        flush = 1'b0;
        id_valid = 1'b0;
        id_payload = '0;
        mem_allowin = 1'b1;
        data_sram_addr_ok = 1'b0;
        mem_ex = 1'b0;
        wb_ex = 1'b0;
        lfsr_data = 32'hd584;
        lfsr_sram = 32'hd584;
        error_count = 0;

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        #1;
        check_value("exe_to_mem_valid", exe_to_mem_valid, 1'b0);
        check_value("data_sram.req", data_sram.req, 1'b0);
        check_value("exe_allowin", exe_allowin, 1'b1);

        test_alu();
        test_mul();
        test_mem_access();
        test_align();
        test_stall();
        test_counter();

        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire
